/* include/decode_macros.svh */
// Decode encodings and control word layout
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define OP_RTYPE  6'h03 // Integer R-type
`define OP_COP1   6'h11 // Coprocessor 1 arithmetic and branches
`define OP_ADDI   6'h09
`define OP_ADDIU  6'h08
`define OP_ANDI   6'h0C
`define OP_LUI    6'h0F
`define OP_ORI    6'h0E
`define OP_BEQ    6'h05
`define OP_BNE    6'h04
`define OP_LW     6'h12
`define OP_LBU    6'h22
`define OP_SW     6'h2B
`define OP_SB     6'h28
`define OP_J      6'h02
`define OP_JAL    6'h07
`define OP_LWC1   6'h31 // FP load single
`define OP_LDC1   6'h35 // FP load double
`define OP_SWC1   6'h39 // FP store single
`define OP_SDC1   6'h3D // FP store double

`define FN_SLL    6'h00
`define FN_SRL    6'h02
`define FN_JR     6'h08
`define FN_SWR    6'h13 // R-encoded store word
`define FN_AND    6'h14
`define FN_ADD    6'h20
`define FN_LWR    6'h21 // R-encoded load word
`define FN_SUBU   6'h22
`define FN_SUB    6'h24
`define FN_OR     6'h25
`define FN_NOR    6'h27
`define FN_SLT    6'h2A
`define FN_SLTU   6'h2B
`define FN_FADD   6'h00
`define FN_FC_EQ  6'h32
`define FN_FC_LT  6'h3C
`define FN_FC_LE  6'h3E

`define FMT_BC    5'h08 // FP branch group
`define FMT_S     5'h10
`define FMT_D     5'h11
`define FT_BC1T   5'h01
`define FT_BC1F   5'h00

`define ALU_SRC_REG  2'd0 // Register operand
`define ALU_SRC_SEXT 2'd1 // Sign-extended immediate
`define ALU_SRC_ZEXT 2'd2 // Zero-extended immediate
`define WB_ALU    2'b11
`define WB_LOAD   2'b01
`define WB_LINK   2'b10
`define WB_NONE   2'b00
`define MEM_WRITE 2'b10
`define MEM_READ  2'b01
`define MEM_NONE  2'b00

`define CW_ALU_SRC  1:0
`define CW_ALU_CTRL 13:2
`define CW_JR       14 // Active low
`define CW_JMP      15 // Active low
`define CW_BEQ      16
`define CW_BNE      17
`define CW_REG_DST  18
`define CW_WB       20:19
`define CW_MEM      22:21
`define CW_RT_RD    23

`endif

/* source/isa_pkg.sv */
// Instruction field types
package isa_pkg;

	// Primary opcode, bits 31..26
	typedef logic [5:0] opcode_t;

	// R-type and FR function field
	typedef logic [5:0] funct_t;

	// Coprocessor format, selects single, double or branch group
	typedef logic [4:0] fmt_t;

	// FP target register, doubles as branch condition
	typedef logic [4:0] ft_t;

endpackage

/* source/ctrl_pkg.sv */
// Control word types
`include "decode_macros.svh"

package ctrl_pkg;

	typedef logic [23:0] ctrl_word_t; // Full packed word
	typedef logic [1:0]  alu_src_t;   // Reg, sext imm, zext imm
	typedef logic [11:0] alu_ctrl_t;  // Opcode and funct
	typedef logic [1:0]  wb_ctrl_t;   // MemToReg, RegWrite
	typedef logic [1:0]  mem_ctrl_t;  // MemWrite, MemRead

	// Places each field at its slot in the word
	function automatic ctrl_word_t build_word(
		input alu_src_t  alu_src,
		input alu_ctrl_t alu_ctrl,
		input logic      jr_n,
		input logic      jmp_n,
		input logic      beq,
		input logic      bne,
		input logic      reg_dst,
		input wb_ctrl_t  wb,
		input mem_ctrl_t mem,
		input logic      rt_rd
	);
		ctrl_word_t w;
		w = '0;
		w[`CW_ALU_SRC]  = alu_src;
		w[`CW_ALU_CTRL] = alu_ctrl;
		w[`CW_JR]       = jr_n;
		w[`CW_JMP]      = jmp_n;
		w[`CW_BEQ]      = beq;
		w[`CW_BNE]      = bne;
		w[`CW_REG_DST]  = reg_dst;
		w[`CW_WB]       = wb;
		w[`CW_MEM]      = mem;
		w[`CW_RT_RD]    = rt_rd;
		return w;
	endfunction

endpackage

/* source/decode_if.sv */
// Sub-decoder result bus
`timescale 1ns/1ps

interface decode_if;
	import ctrl_pkg::*;

	logic       hit;                // Encoding recognised
	ctrl_word_t word;               // Zero without hit
	logic       jal_control;
	logic       id_flush;
	logic       if_flush;
	logic       store_byte_control;
	logic       load_byte_control;
	logic       float_control;      // FP register file path
	logic       bc1f_control;
	logic       bc1t_control;
	logic       mem_to_reg64;       // Double load
	logic       mem_write64;        // Double store
	logic       fp_write_control;   // FP condition flag write

	modport decoder (
		output hit, word, jal_control, id_flush, if_flush, store_byte_control,
			load_byte_control, float_control, bc1f_control, bc1t_control,
			mem_to_reg64, mem_write64, fp_write_control
	);

	modport sink (
		input hit, word, jal_control, id_flush, if_flush, store_byte_control,
			load_byte_control, float_control, bc1f_control, bc1t_control,
			mem_to_reg64, mem_write64, fp_write_control
	);

endinterface

/* source/int_rtype_decoder.sv */
// Integer R-type decoder
`timescale 1ns/1ps
`include "decode_macros.svh"

module int_rtype_decoder (
	input  isa_pkg::opcode_t op_code,
	input  isa_pkg::funct_t  funct,
	decode_if.decoder        out
);
	import ctrl_pkg::*;

	logic      alu_op; // Plain register ALU op
	logic      jr_op;
	logic      lw_op;  // R-encoded load word
	logic      sw_op;  // R-encoded store word
	logic      hit;
	logic      mem_op;
	wb_ctrl_t  wb;
	mem_ctrl_t mem;

	always_comb begin
		alu_op = 1'b0;
		jr_op  = 1'b0;
		lw_op  = 1'b0;
		sw_op  = 1'b0;
		if (op_code == `OP_RTYPE) begin
			case (funct)
				`FN_AND, `FN_ADD, `FN_NOR, `FN_OR, `FN_SLT,
				`FN_SLTU, `FN_SLL, `FN_SRL, `FN_SUB, `FN_SUBU: alu_op = 1'b1;
				`FN_JR:  jr_op = 1'b1;
				`FN_LWR: lw_op = 1'b1;
				`FN_SWR: sw_op = 1'b1;
				default: alu_op = 1'b0; // Unsupported funct, no hit
			endcase
		end
	end

	assign hit    = alu_op | jr_op | lw_op | sw_op;
	assign mem_op = lw_op | sw_op; // Both use Rt and RegDst

	// Write-back and memory fields
	assign wb  = alu_op ? `WB_ALU : (jr_op ? `WB_LINK : (lw_op ? `WB_LOAD : `WB_NONE));
	assign mem = lw_op ? `MEM_READ : (sw_op ? `MEM_WRITE : `MEM_NONE);

	assign out.hit  = hit;
	assign out.word = hit ? build_word(`ALU_SRC_REG, {op_code, funct}, ~jr_op, ~jr_op,
		1'b0, 1'b0, mem_op, wb, mem, mem_op) : '0;

	assign out.jal_control        = 1'b0;
	assign out.id_flush           = 1'b0;
	assign out.if_flush           = jr_op; // Drop the fetched slot on jr
	assign out.store_byte_control = 1'b0;
	assign out.load_byte_control  = 1'b0;
	assign out.float_control      = 1'b0;
	assign out.bc1f_control       = 1'b0;
	assign out.bc1t_control       = 1'b0;
	assign out.mem_to_reg64       = 1'b0;
	assign out.mem_write64        = 1'b0;
	assign out.fp_write_control   = 1'b0;

endmodule

/* source/int_itype_decoder.sv */
// Integer immediate and jump decoder
`timescale 1ns/1ps
`include "decode_macros.svh"

module int_itype_decoder (
	input  isa_pkg::opcode_t op_code,
	input  isa_pkg::funct_t  funct,
	decode_if.decoder        out
);
	import ctrl_pkg::*;

	logic      hit;
	alu_src_t  alu_src;
	logic      jr_n;       // Active low jump-register select
	logic      jmp_n;      // Active low jump select
	logic      beq;
	logic      bne;
	logic      reg_dst;
	wb_ctrl_t  wb;
	mem_ctrl_t mem;
	logic      load_byte;
	logic      store_byte;
	logic      jal;
	logic      if_flush;

	always_comb begin
		hit        = 1'b1;
		alu_src    = `ALU_SRC_REG;
		jr_n       = 1'b1;
		jmp_n      = 1'b1;
		beq        = 1'b0;
		bne        = 1'b0;
		reg_dst    = 1'b0;
		wb         = `WB_NONE;
		mem        = `MEM_NONE;
		load_byte  = 1'b0;
		store_byte = 1'b0;
		jal        = 1'b0;
		if_flush   = 1'b0;
		case (op_code)
			`OP_ADDI, `OP_ADDIU: begin
				alu_src = `ALU_SRC_SEXT;
				reg_dst = 1'b1;
				wb      = `WB_ALU;
			end
			`OP_ANDI: begin
				alu_src = `ALU_SRC_ZEXT; // Rd kept as destination
				wb      = `WB_ALU;
			end
			`OP_LUI, `OP_ORI: begin
				alu_src = `ALU_SRC_ZEXT;
				reg_dst = 1'b1;
				wb      = `WB_ALU;
			end
			`OP_BEQ: beq = 1'b1;
			`OP_BNE: bne = 1'b1;
			`OP_LW, `OP_LBU: begin
				alu_src   = `ALU_SRC_SEXT; // Base plus offset
				reg_dst   = 1'b1;
				wb        = `WB_LOAD;
				mem       = `MEM_READ;
				load_byte = (op_code == `OP_LBU);
			end
			`OP_SW, `OP_SB: begin
				alu_src    = `ALU_SRC_SEXT;
				reg_dst    = 1'b1;
				mem        = `MEM_WRITE;
				store_byte = (op_code == `OP_SB);
			end
			`OP_J: begin
				jmp_n    = 1'b0;
				if_flush = 1'b1;
			end
			`OP_JAL: begin
				jr_n     = 1'b0;
				jmp_n    = 1'b0;
				wb       = `WB_LINK; // Return address to $ra
				if_flush = 1'b1;
				jal      = 1'b1;
			end
			default: hit = 1'b0;
		endcase
	end

	assign out.hit  = hit;
	assign out.word = hit ? build_word(alu_src, {op_code, funct}, jr_n, jmp_n, beq, bne,
		reg_dst, wb, mem, 1'b0) : '0;

	assign out.jal_control        = jal;
	assign out.id_flush           = 1'b0;
	assign out.if_flush           = if_flush;
	assign out.store_byte_control = store_byte;
	assign out.load_byte_control  = load_byte;
	assign out.float_control      = 1'b0;
	assign out.bc1f_control       = 1'b0;
	assign out.bc1t_control       = 1'b0;
	assign out.mem_to_reg64       = 1'b0;
	assign out.mem_write64        = 1'b0;
	assign out.fp_write_control   = 1'b0;

endmodule

/* source/cop1_decoder.sv */
// Coprocessor 1 decoder
`timescale 1ns/1ps
`include "decode_macros.svh"

module cop1_decoder (
	input  isa_pkg::opcode_t op_code,
	input  isa_pkg::funct_t  funct,
	input  isa_pkg::fmt_t    fmt,
	input  isa_pkg::ft_t     ft,
	decode_if.decoder        out
);
	import ctrl_pkg::*;

	logic      hit;
	logic      fp_mem;   // Any FP load or store
	alu_src_t  alu_src;
	wb_ctrl_t  wb;
	mem_ctrl_t mem;
	logic      branch;   // Both flushes on FP branch
	logic      bc1t;
	logic      bc1f;
	logic      fp_float;
	logic      to_reg64;
	logic      write64;
	logic      fp_write;

	always_comb begin
		hit      = 1'b0;
		fp_mem   = 1'b0;
		alu_src  = `ALU_SRC_REG;
		wb       = `WB_NONE;
		mem      = `MEM_NONE;
		branch   = 1'b0;
		bc1t     = 1'b0;
		bc1f     = 1'b0;
		fp_float = 1'b0;
		to_reg64 = 1'b0;
		write64  = 1'b0;
		fp_write = 1'b0;
		case (op_code)
			`OP_COP1: begin
				if (fmt == `FMT_BC && (ft == `FT_BC1T || ft == `FT_BC1F)) begin
					hit    = 1'b1;
					branch = 1'b1;
					bc1t   = (ft == `FT_BC1T);
					bc1f   = (ft == `FT_BC1F);
				end else if (fmt == `FMT_S || fmt == `FMT_D) begin
					fp_write = (funct == `FN_FC_EQ) || (funct == `FN_FC_LT) ||
						(funct == `FN_FC_LE); // Compare sets condition flag
					hit      = fp_write || (funct == `FN_FADD);
					fp_float = hit;
					wb       = hit ? `WB_ALU : `WB_NONE;
				end
			end
			`OP_LWC1, `OP_LDC1: begin
				hit      = 1'b1;
				fp_mem   = 1'b1;
				alu_src  = `ALU_SRC_SEXT;
				wb       = `WB_LOAD;
				mem      = `MEM_READ;
				fp_float = 1'b1;
				to_reg64 = (op_code == `OP_LDC1); // Register pair write
			end
			`OP_SWC1, `OP_SDC1: begin
				hit      = 1'b1;
				fp_mem   = 1'b1;
				alu_src  = `ALU_SRC_SEXT;
				mem      = `MEM_WRITE;
				fp_float = 1'b1;
				write64  = (op_code == `OP_SDC1);
			end
			default: hit = 1'b0;
		endcase
	end

	assign out.hit  = hit;
	assign out.word = hit ? build_word(alu_src, {op_code, funct}, 1'b1, 1'b1, 1'b0, 1'b0,
		fp_mem, wb, mem, 1'b0) : '0;

	assign out.jal_control        = 1'b0;
	assign out.id_flush           = branch;
	assign out.if_flush           = branch;
	assign out.store_byte_control = 1'b0;
	assign out.load_byte_control  = 1'b0;
	assign out.float_control      = fp_float;
	assign out.bc1f_control       = bc1f;
	assign out.bc1t_control       = bc1t;
	assign out.mem_to_reg64       = to_reg64;
	assign out.mem_write64        = write64;
	assign out.fp_write_control   = fp_write;

endmodule

/* source/control_register.sv */
// Decode output register
`timescale 1ns/1ps

module control_register (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	decode_if.sink               rtype,
	decode_if.sink               itype,
	decode_if.sink               cop1,
	output logic                 ctrl_valid,
	output logic                 unknown_instr,
	output ctrl_pkg::ctrl_word_t control_signal,
	output logic                 jal_control,
	output logic                 id_flush,
	output logic                 if_flush,
	output logic                 store_byte_control,
	output logic                 load_byte_control,
	output logic                 float_control,
	output logic                 bc1f_control,
	output logic                 bc1t_control,
	output logic                 mem_to_reg64,
	output logic                 mem_write64,
	output logic                 fp_write_control
);
	import ctrl_pkg::*;

	logic       any_hit;
	ctrl_word_t merged_word;  // Non-hitting buses are zero
	logic [10:0] rtype_flags;
	logic [10:0] itype_flags;
	logic [10:0] cop1_flags;
	logic [10:0] flags_q;

	assign any_hit     = rtype.hit | itype.hit | cop1.hit;
	assign merged_word = rtype.word | itype.word | cop1.word;

	// Same flag order on every bus
	assign rtype_flags = {rtype.jal_control, rtype.id_flush, rtype.if_flush,
		rtype.store_byte_control, rtype.load_byte_control, rtype.float_control,
		rtype.bc1f_control, rtype.bc1t_control, rtype.mem_to_reg64, rtype.mem_write64,
		rtype.fp_write_control};
	assign itype_flags = {itype.jal_control, itype.id_flush, itype.if_flush,
		itype.store_byte_control, itype.load_byte_control, itype.float_control,
		itype.bc1f_control, itype.bc1t_control, itype.mem_to_reg64, itype.mem_write64,
		itype.fp_write_control};
	assign cop1_flags = {cop1.jal_control, cop1.id_flush, cop1.if_flush,
		cop1.store_byte_control, cop1.load_byte_control, cop1.float_control,
		cop1.bc1f_control, cop1.bc1t_control, cop1.mem_to_reg64, cop1.mem_write64,
		cop1.fp_write_control};

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_valid     <= 1'b0;
			unknown_instr  <= 1'b0;
			control_signal <= '0;
			flags_q        <= '0;
		end else begin
			ctrl_valid     <= instr_valid;
			unknown_instr  <= instr_valid & ~any_hit;             // No decoder claimed it
			control_signal <= instr_valid ? merged_word : '0;     // Bubble loads zeros
			flags_q        <= instr_valid ? (rtype_flags | itype_flags | cop1_flags) : '0;
		end
	end

	assign {jal_control, id_flush, if_flush, store_byte_control, load_byte_control,
		float_control, bc1f_control, bc1t_control, mem_to_reg64, mem_write64,
		fp_write_control} = flags_q;

	// Decoders own disjoint encodings
	single_hit: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> $onehot0({rtype.hit, itype.hit, cop1.hit}));

	// ID flush never without IF flush
	flush_order: assert property (@(posedge clk) disable iff (reset)
		id_flush |-> if_flush);

endmodule

/* source/control_unit.sv */
// Registered decode control unit
`timescale 1ns/1ps

module control_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  isa_pkg::opcode_t     op_code,
	input  isa_pkg::funct_t      funct,
	input  isa_pkg::fmt_t        fmt,
	input  isa_pkg::ft_t         ft,
	output logic                 ctrl_valid,
	output logic                 unknown_instr,
	output ctrl_pkg::ctrl_word_t control_signal,
	output logic                 jal_control,
	output logic                 id_flush,
	output logic                 if_flush,
	output logic                 store_byte_control,
	output logic                 load_byte_control,
	output logic                 float_control,
	output logic                 bc1f_control,
	output logic                 bc1t_control,
	output logic                 mem_to_reg64,
	output logic                 mem_write64,
	output logic                 fp_write_control
);

	decode_if rtype_bus ();  // Opcode 03 results
	decode_if itype_bus ();  // Integer immediate and jumps
	decode_if cop1_bus ();   // FP arithmetic, branches, memory

	int_rtype_decoder rtype_decoder_inst (
		.op_code (op_code),
		.funct   (funct),
		.out     (rtype_bus)
	);

	int_itype_decoder itype_decoder_inst (
		.op_code (op_code),
		.funct   (funct),
		.out     (itype_bus)
	);

	cop1_decoder cop1_decoder_inst (
		.op_code (op_code),
		.funct   (funct),
		.fmt     (fmt),
		.ft      (ft),
		.out     (cop1_bus)
	);

	control_register control_register_inst (
		.clk                (clk),
		.reset              (reset),
		.instr_valid        (instr_valid),
		.rtype              (rtype_bus),
		.itype              (itype_bus),
		.cop1               (cop1_bus),
		.ctrl_valid         (ctrl_valid),
		.unknown_instr      (unknown_instr),
		.control_signal     (control_signal),
		.jal_control        (jal_control),
		.id_flush           (id_flush),
		.if_flush           (if_flush),
		.store_byte_control (store_byte_control),
		.load_byte_control  (load_byte_control),
		.float_control      (float_control),
		.bc1f_control       (bc1f_control),
		.bc1t_control       (bc1t_control),
		.mem_to_reg64       (mem_to_reg64),
		.mem_write64        (mem_write64),
		.fp_write_control   (fp_write_control)
	);

endmodule

/* verif/tb_control_unit.sv */
// Control unit testbench
`timescale 1ns/1ps
`include "decode_macros.svh"

module tb_control_unit;
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	opcode_t     op_code;
	funct_t      funct;
	fmt_t        fmt;
	ft_t         ft;
	logic        ctrl_valid;
	logic        unknown_instr;
	ctrl_word_t  control_signal;
	logic        jal_control;
	logic        id_flush;
	logic        if_flush;
	logic        store_byte_control;
	logic        load_byte_control;
	logic        float_control;
	logic        bc1f_control;
	logic        bc1t_control;
	logic        mem_to_reg64;
	logic        mem_write64;
	logic        fp_write_control;

	logic [31:0] lfsr;            // Stimulus generator state
	ctrl_word_t  exp_word_q [$];  // One entry per driven cycle
	logic [12:0] exp_bits_q [$];  // Valid, unknown, eleven flags

	opcode_t int_ops [0:13] = '{`OP_RTYPE, `OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_LUI, `OP_ORI,
		`OP_BEQ, `OP_BNE, `OP_LW, `OP_LBU, `OP_SW, `OP_SB, `OP_J, `OP_JAL};
	funct_t  r_functs [0:12] = '{`FN_AND, `FN_ADD, `FN_NOR, `FN_OR, `FN_SLT, `FN_SLTU,
		`FN_SLL, `FN_SRL, `FN_SUB, `FN_SUBU, `FN_JR, `FN_LWR, `FN_SWR};
	opcode_t cop1_ops [0:4] = '{`OP_COP1, `OP_LWC1, `OP_LDC1, `OP_SWC1, `OP_SDC1};
	funct_t  fp_functs [0:3] = '{`FN_FADD, `FN_FC_EQ, `FN_FC_LT, `FN_FC_LE};
	fmt_t    fmts [0:2] = '{`FMT_BC, `FMT_S, `FMT_D};

	control_unit control_unit_inst (
		.clk                (clk),
		.reset              (reset),
		.instr_valid        (instr_valid),
		.op_code            (op_code),
		.funct              (funct),
		.fmt                (fmt),
		.ft                 (ft),
		.ctrl_valid         (ctrl_valid),
		.unknown_instr      (unknown_instr),
		.control_signal     (control_signal),
		.jal_control        (jal_control),
		.id_flush           (id_flush),
		.if_flush           (if_flush),
		.store_byte_control (store_byte_control),
		.load_byte_control  (load_byte_control),
		.float_control      (float_control),
		.bc1f_control       (bc1f_control),
		.bc1t_control       (bc1t_control),
		.mem_to_reg64       (mem_to_reg64),
		.mem_write64        (mem_write64),
		.fp_write_control   (fp_write_control)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic pick_index(input int n, output int idx);
		logic [31:0] r;
		take_bits(8, r);
		idx = r % n;
	endtask

	task automatic fail_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input ctrl_word_t got, input ctrl_word_t exp);
		if (got !== exp) begin
			$display("error: %s got 0x%06h expected 0x%06h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
			fail_run();
		end
	endtask

	// Expected outputs one edge after these inputs
	task automatic decode_model(input logic rst, input logic vld, input opcode_t op,
		input funct_t fn, input fmt_t fm, input ft_t t,
		output ctrl_word_t w, output logic [12:0] b);
		alu_src_t    src;
		wb_ctrl_t    wb;
		mem_ctrl_t   mem;
		logic        jr_n, jmp_n, beq, bne;
		logic        rdst, rtrd, hit;
		logic [10:0] fl; // jal, id, if, sb, lb, float, bc1f, bc1t, r64, w64, fpw
		src = 2'd0;
		wb = 2'b00;
		mem = 2'b00;
		jr_n = 1'b1; // Both jump selects idle high
		jmp_n = 1'b1;
		beq = 1'b0;
		bne = 1'b0;
		rdst = 1'b0;
		rtrd = 1'b0;
		hit = 1'b1;
		fl = '0;
		if (op == 6'h03) begin
			case (fn)
				6'h14, 6'h20, 6'h27, 6'h25, 6'h2A, 6'h2B, 6'h00, 6'h02, 6'h24, 6'h22:
					wb = 2'b11;
				6'h08: begin
					jr_n = 1'b0;
					jmp_n = 1'b0;
					wb = 2'b10;
					fl[8] = 1'b1;
				end
				6'h21: begin
					rdst = 1'b1;
					wb = 2'b01;
					mem = 2'b01;
					rtrd = 1'b1;
				end
				6'h13: begin
					rdst = 1'b1;
					mem = 2'b10;
					rtrd = 1'b1;
				end
				default: hit = 1'b0;
			endcase
		end else if (op == 6'h11) begin
			if (fm == 5'h08 && (t == 5'h01 || t == 5'h00)) begin
				fl[9] = 1'b1;
				fl[8] = 1'b1;
				fl[3] = (t == 5'h01); // bc1t
				fl[4] = (t == 5'h00); // bc1f
			end else if ((fm == 5'h10 || fm == 5'h11) &&
				(fn == 6'h00 || fn == 6'h32 || fn == 6'h3C || fn == 6'h3E)) begin
				wb = 2'b11;
				fl[5] = 1'b1;
				fl[0] = (fn != 6'h00); // Compares only
			end else begin
				hit = 1'b0;
			end
		end else begin
			case (op)
				6'h09, 6'h08: begin
					src = 2'd1;
					rdst = 1'b1;
					wb = 2'b11;
				end
				6'h0C: begin
					src = 2'd2;
					wb = 2'b11;
				end
				6'h0F, 6'h0E: begin
					src = 2'd2;
					rdst = 1'b1;
					wb = 2'b11;
				end
				6'h05: beq = 1'b1;
				6'h04: bne = 1'b1;
				6'h12, 6'h22, 6'h31, 6'h35: begin
					src = 2'd1;
					rdst = 1'b1;
					wb = 2'b01;
					mem = 2'b01;
					fl[6] = (op == 6'h22);
					fl[5] = (op == 6'h31 || op == 6'h35);
					fl[2] = (op == 6'h35); // Double load
				end
				6'h2B, 6'h28, 6'h39, 6'h3D: begin
					src = 2'd1;
					rdst = 1'b1;
					mem = 2'b10;
					fl[7] = (op == 6'h28);
					fl[5] = (op == 6'h39 || op == 6'h3D);
					fl[1] = (op == 6'h3D); // Double store
				end
				6'h02: begin
					jmp_n = 1'b0;
					fl[8] = 1'b1;
				end
				6'h07: begin
					jr_n = 1'b0;
					jmp_n = 1'b0;
					wb = 2'b10;
					fl[8] = 1'b1;
					fl[10] = 1'b1;
				end
				default: hit = 1'b0;
			endcase
		end
		w = '0;
		w[`CW_ALU_SRC] = src;
		w[`CW_ALU_CTRL] = {op, fn};
		w[`CW_JR] = jr_n;
		w[`CW_JMP] = jmp_n;
		w[`CW_BEQ] = beq;
		w[`CW_BNE] = bne;
		w[`CW_REG_DST] = rdst;
		w[`CW_WB] = wb;
		w[`CW_MEM] = mem;
		w[`CW_RT_RD] = rtrd;
		if (rst || !vld) begin
			w = '0; // Reset and bubbles clear everything
			b = '0;
		end else if (!hit) begin
			w = '0;
			b = {1'b1, 1'b1, 11'b0}; // Unknown encoding
		end else begin
			b = {1'b1, 1'b0, fl};
		end
	endtask

	task automatic check_outputs();
		ctrl_word_t  w;
		logic [12:0] b;
		w = exp_word_q.pop_front();
		b = exp_bits_q.pop_front();
		check_bit("ctrl_valid", ctrl_valid, b[12]);
		check_bit("unknown_instr", unknown_instr, b[11]);
		check_bit("jal_control", jal_control, b[10]);
		check_bit("id_flush", id_flush, b[9]);
		check_bit("if_flush", if_flush, b[8]);
		check_bit("store_byte_control", store_byte_control, b[7]);
		check_bit("load_byte_control", load_byte_control, b[6]);
		check_bit("float_control", float_control, b[5]);
		check_bit("bc1f_control", bc1f_control, b[4]);
		check_bit("bc1t_control", bc1t_control, b[3]);
		check_bit("mem_to_reg64", mem_to_reg64, b[2]);
		check_bit("mem_write64", mem_write64, b[1]);
		check_bit("fp_write_control", fp_write_control, b[0]);
		check_word("control_signal", control_signal, w);
	endtask

	// Drive one cycle, then check the previous cycle's result
	task automatic step(input logic rst, input logic vld, input opcode_t op,
		input funct_t fn, input fmt_t fm, input ft_t t);
		ctrl_word_t  w;
		logic [12:0] b;
		@(posedge clk);
		reset       <= rst;
		instr_valid <= vld;
		op_code     <= op;
		funct       <= fn;
		fmt         <= fm;
		ft          <= t;
		decode_model(rst, vld, op, fn, fm, t, w, b);
		exp_word_q.push_back(w);
		exp_bits_q.push_back(b);
		@(negedge clk); // Outputs settled mid-cycle
		check_outputs();
	endtask

	task automatic wait_result();
		int cycles;
		cycles = 0;
		while (ctrl_valid !== 1'b1) begin
			if (cycles == 8) begin
				$display("timed out waiting for ctrl_valid after the first instruction");
				fail_run();
			end
			step(1'b0, 1'b0, '0, '0, '0, '0);
			cycles++;
		end
	endtask

	// Half from the supported lists, half raw
	task automatic pick_int(output opcode_t op, output funct_t fn, output fmt_t fm,
		output ft_t t);
		logic [31:0] r;
		int          idx;
		take_bits(1, r);
		if (r[0]) begin
			pick_index(14, idx);
			op = int_ops[idx];
		end else begin
			take_bits(6, r);
			op = r[5:0];
		end
		take_bits(1, r);
		if (r[0]) begin
			pick_index(13, idx);
			fn = r_functs[idx];
		end else begin
			take_bits(6, r);
			fn = r[5:0];
		end
		take_bits(5, r);
		fm = r[4:0];
		take_bits(5, r);
		t = r[4:0];
	endtask

	task automatic pick_cop1(output opcode_t op, output funct_t fn, output fmt_t fm,
		output ft_t t);
		logic [31:0] r;
		int          idx;
		take_bits(1, r);
		if (r[0]) begin
			pick_index(5, idx);
			op = cop1_ops[idx];
		end else begin
			take_bits(6, r);
			op = r[5:0];
		end
		take_bits(1, r);
		if (r[0]) begin
			pick_index(4, idx);
			fn = fp_functs[idx];
		end else begin
			take_bits(6, r);
			fn = r[5:0];
		end
		take_bits(1, r);
		if (r[0]) begin
			pick_index(3, idx);
			fm = fmts[idx];
		end else begin
			take_bits(5, r);
			fm = r[4:0];
		end
		take_bits(1, r);
		if (r[0]) begin
			take_bits(1, r);
			t = {4'b0, r[0]}; // Branch sense 0 or 1
		end else begin
			take_bits(5, r);
			t = r[4:0];
		end
	endtask

	task automatic pick_raw(output opcode_t op, output funct_t fn, output fmt_t fm,
		output ft_t t);
		logic [31:0] r;
		take_bits(22, r);
		{op, fn, fm, t} = r[21:0];
	endtask

	task automatic pick_any(output opcode_t op, output funct_t fn, output fmt_t fm,
		output ft_t t);
		logic [31:0] r;
		take_bits(2, r);
		if (r[1:0] == 2'd2)
			pick_cop1(op, fn, fm, t);
		else if (r[1:0] == 2'd3)
			pick_raw(op, fn, fm, t);
		else
			pick_int(op, fn, fm, t);
	endtask

	initial begin
		ctrl_word_t  w0;
		logic [12:0] b0;
		opcode_t     op;
		funct_t      fn;
		fmt_t        fm;
		ft_t         t;
		logic [31:0] r;
		int          tries;
		lfsr        = 32'h05211960;
		reset       = 1'b1;
		instr_valid = 1'b0;
		op_code     = '0;
		funct       = '0;
		fmt         = '0;
		ft          = '0;
		decode_model(1'b1, 1'b0, '0, '0, '0, '0, w0, b0); // Values before the first edge
		exp_word_q.push_back(w0);
		exp_bits_q.push_back(b0);
		repeat (10) step(1'b1, 1'b0, '0, '0, '0, '0);
		repeat (3) step(1'b0, 1'b0, '0, '0, '0, '0); // Idle after release
		pick_int(op, fn, fm, t);
		step(1'b0, 1'b1, op, fn, fm, t);
		wait_result();
		repeat (300) begin // Back-to-back integer
			pick_int(op, fn, fm, t);
			step(1'b0, 1'b1, op, fn, fm, t);
		end
		repeat (300) begin // Coprocessor 1
			pick_cop1(op, fn, fm, t);
			step(1'b0, 1'b1, op, fn, fm, t);
		end
		repeat (150) begin
			tries = 0;
			do begin // Bias toward unknown encodings
				pick_raw(op, fn, fm, t);
				decode_model(1'b0, 1'b1, op, fn, fm, t, w0, b0);
				tries++;
			end while (!b0[11] && tries < 16);
			step(1'b0, 1'b1, op, fn, fm, t);
		end
		repeat (200) begin // Bubbles mixed in
			pick_any(op, fn, fm, t);
			take_bits(2, r);
			step(1'b0, r[1:0] != 2'b00, op, fn, fm, t);
		end
		repeat (3) begin
			repeat (20) begin
				pick_any(op, fn, fm, t);
				step(1'b0, 1'b1, op, fn, fm, t);
			end
			repeat (2) begin // Reset over valid traffic
				pick_any(op, fn, fm, t);
				step(1'b1, 1'b1, op, fn, fm, t);
			end
		end
		step(1'b0, 1'b0, '0, '0, '0, '0); // Flush last result
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* compile.f */
+incdir+include
source/isa_pkg.sv
source/ctrl_pkg.sv
source/decode_if.sv
source/int_rtype_decoder.sv
source/int_itype_decoder.sv
source/cop1_decoder.sv
source/control_register.sv
source/control_unit.sv
verif/tb_control_unit.sv
